// ==== hazard_settings.svh ====
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// Datapath and address width
`define HAZ_DATA_W 16

// Eight architectural registers
`define HAZ_REG_W 3

// Shadowed stages ID, EX, MEM, WB
`define HAZ_STAGES 4

// Direct jump opcodes, instr[15:11]
`define HAZ_OP_J   5'b00100
`define HAZ_OP_JAL 5'b00110

// JAL writes its return address here
`define HAZ_LINK_REG 3'd7

`endif

// ==== hazardPkg.sv ====
`include "hazard_settings.svh"

package hazardPkg;

    // Decoded fields of the instruction word in fetch
    typedef struct packed {
        logic [4:0]            opcode; // instr[15:11]
        logic [`HAZ_REG_W-1:0] rs;     // instr[10:8]
        logic [`HAZ_REG_W-1:0] rt;     // instr[7:5]
    } instrFields;

    // Register write record shadowing one stage
    // Valid bit sits in the LSB so the shadow pipeline can cull it
    typedef struct packed {
        logic [`HAZ_REG_W-1:0] rd;    // Destination register
        logic                  valid; // Instruction writes rd
    } regRecord;

    // Memory access record shadowing one stage
    typedef struct packed {
        logic [`HAZ_DATA_W-1:0] addr;  // reg1Data + imm
        logic                   memEn; // Stage accesses memory
    } memRecord;

    // Forwarding paths for the instruction in fetch
    // MSB first, in the order of the 6-bit forwarding bus
    typedef struct packed {
        logic exToExRs;  // ID record feeds rs
        logic memToExRs; // EX record feeds rs
        logic exToExRt;  // ID record feeds rt
        logic memToExRt; // EX record feeds rt
        logic exToIdRs;  // EX record feeds rs at decode
        logic memToIdRs; // MEM record feeds rs at decode
    } fwdFlags;

endpackage

// ==== instrDecode.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module instrDecode (
    input  logic [`HAZ_DATA_W-1:0] instr,  // Instruction word from fetch
    output hazardPkg::instrFields  fields, // Opcode and source registers
    output logic                   isJump, // J or JAL, needs one bubble
    output logic                   isLink  // JAL, writes the link register
);

    localparam int OpMsb = `HAZ_DATA_W - 1;
    localparam int RsMsb = OpMsb - 5;          // Opcode is five bits wide
    localparam int RtMsb = RsMsb - `HAZ_REG_W;

    logic [4:0] opcode;

    assign opcode = instr[OpMsb -: 5];

    // Field split, same layout for every format that reads registers
    assign fields.opcode = opcode;
    assign fields.rs     = instr[RsMsb -: `HAZ_REG_W];
    assign fields.rt     = instr[RtMsb -: `HAZ_REG_W];

    always_comb begin
        isJump = 1'b0;
        isLink = 1'b0;
        case (opcode)
            `HAZ_OP_J: begin
                isJump = 1'b1;      // Plain jump
            end
            `HAZ_OP_JAL: begin
                isJump = 1'b1;
                isLink = 1'b1;      // Jump and link
            end
            // Branches resolve later through branchTaken
            // JR and JALR are not handled here
            default: begin
                isJump = 1'b0;
                isLink = 1'b0;
            end
        endcase
    end

endmodule

// ==== stagePipe.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

// Shadow of the ID, EX, MEM and WB stages for one record type
// Index 0 is ID, index HAZ_STAGES-1 is WB
module stagePipe #(
    parameter type payloadT = logic  // LSB of the payload is its valid bit
) (
    input  logic                          clk,
    input  logic                          reset,
    input  payloadT                       entryIn,     // Record of the fetched instruction
    input  logic                          stall,       // Bubble enters instead
    input  logic                          branchTaken, // Cull the entry in ID
    output payloadT [`HAZ_STAGES-1:0]     stages       // Visible view
);

    localparam int PayloadW = $bits(payloadT);

    payloadT [`HAZ_STAGES-1:0] stageQ;
    logic    [PayloadW-1:0]    idBits;
    payloadT                   idView;

    // ID entry with its valid bit cleared on a taken branch
    always_comb begin
        idBits    = stageQ[0];
        idBits[0] = idBits[0] & ~branchTaken;
        idView    = payloadT'(idBits);
    end

    always_comb begin
        stages    = stageQ;
        stages[0] = idView;   // Checkers see the culled entry
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stageQ <= '0;                                // All entries invalid
        end else begin
            stageQ[0] <= stall ? payloadT'('0) : entryIn; // Bubble on stall
            stageQ[1] <= idView;                          // Cull moves into EX
            for (int i = 2; i < `HAZ_STAGES; i++) begin
                stageQ[i] <= stageQ[i-1];                 // EX to MEM, MEM to WB
            end
        end
    end

endmodule

// ==== regHazardCheck.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module regHazardCheck (
    input  hazardPkg::instrFields                  fields,    // Sources of the new instruction
    input  hazardPkg::regRecord [`HAZ_STAGES-1:0]  stages,    // Visible register records
    output logic                                   regHazard, // RAW on rs or rt
    output hazardPkg::fwdFlags                     forwards
);

    localparam int IdIdx  = 0;
    localparam int ExIdx  = 1;
    localparam int MemIdx = 2;

    logic [`HAZ_STAGES-1:0] rsHit;
    logic [`HAZ_STAGES-1:0] rtHit;

    // Per stage match against a valid writer
    always_comb begin
        for (int i = 0; i < `HAZ_STAGES; i++) begin
            rsHit[i] = stages[i].valid && (stages[i].rd == fields.rs);
            rtHit[i] = stages[i].valid && (stages[i].rd == fields.rt);
        end
    end

    // Any writer still in flight blocks the read
    // Bubbles and culled entries carry valid low and never match
    assign regHazard = |rsHit || |rtHit;

    // Instruction in ID reaches EX next, so its result forwards EX to EX
    assign forwards.exToExRs  = rsHit[IdIdx];
    assign forwards.exToExRt  = rtHit[IdIdx];

    // One stage further back, the value comes out of MEM
    assign forwards.memToExRs = rsHit[ExIdx];
    assign forwards.memToExRt = rtHit[ExIdx];

    // Decode-side paths, for register jumps
    assign forwards.exToIdRs  = rsHit[ExIdx];
    assign forwards.memToIdRs = rsHit[MemIdx];

endmodule

// ==== memHazardCheck.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module memHazardCheck (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`HAZ_DATA_W-1:0] reg1Data,    // Base register value
    input  logic [`HAZ_DATA_W-1:0] imm,         // Offset
    input  logic                   memEnable,   // New instruction accesses memory
    input  logic                   stall,
    input  logic                   branchTaken,
    output logic                   memHazard    // Same address still in flight
);

    logic [`HAZ_DATA_W-1:0]                   memAddr;
    hazardPkg::memRecord                      memEntry;
    hazardPkg::memRecord [`HAZ_STAGES-1:0]    memStages;
    logic [`HAZ_STAGES-1:0]                   addrHit;

    assign memAddr = reg1Data + imm;   // Carry out dropped

    assign memEntry.addr  = memAddr;
    assign memEntry.memEn = memEnable;

    stagePipe #(
        .payloadT(hazardPkg::memRecord)
    ) memPipe (
        .clk        (clk),
        .reset      (reset),
        .entryIn    (memEntry),
        .stall      (stall),
        .branchTaken(branchTaken),
        .stages     (memStages)
    );

    // Each stage's enable paired with its own address
    always_comb begin
        for (int i = 0; i < `HAZ_STAGES; i++) begin
            addrHit[i] = memStages[i].memEn && (memStages[i].addr == memAddr);
        end
    end

    assign memHazard = memEnable && |addrHit;

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardUnit (
    input  logic [`HAZ_DATA_W-1:0] instr,       // Instruction word in fetch
    input  logic [`HAZ_REG_W-1:0]  rd,          // Destination from the decoder
    input  logic                   writeEn,     // Instruction writes rd
    input  logic                   memEnable,   // Instruction accesses memory
    input  logic [`HAZ_DATA_W-1:0] reg1Data,    // Base for the access address
    input  logic [`HAZ_DATA_W-1:0] imm,         // Offset for the access address
    input  logic                   branchTaken, // Squash the instruction in ID
    input  logic                   clk,
    input  logic                   reset,
    output logic                   nop,         // Insert a bubble
    output logic                   pcStall,     // Hold the PC
    output hazardPkg::fwdFlags     forwards
);

    hazardPkg::instrFields                  fields;
    logic                                   isJump;
    logic                                   isLink;
    hazardPkg::regRecord                    regEntry;
    hazardPkg::regRecord [`HAZ_STAGES-1:0]  regStages;
    logic                                   regHazard;
    logic                                   memHazard;
    logic                                   jumpBubble; // Jump already took its bubble
    logic                                   jumpNop;
    logic                                   stall;

    instrDecode decode0 (
        .instr (instr),
        .fields(fields),
        .isJump(isJump),
        .isLink(isLink)
    );

    // JAL writes the link register regardless of rd
    assign regEntry.rd    = isLink ? `HAZ_LINK_REG : rd;
    assign regEntry.valid = writeEn;

    stagePipe #(
        .payloadT(hazardPkg::regRecord)
    ) regPipe (
        .clk        (clk),
        .reset      (reset),
        .entryIn    (regEntry),
        .stall      (stall),
        .branchTaken(branchTaken),
        .stages     (regStages)
    );

    regHazardCheck regCheck0 (
        .fields   (fields),
        .stages   (regStages),
        .regHazard(regHazard),
        .forwards (forwards)
    );

    memHazardCheck memCheck0 (
        .clk        (clk),
        .reset      (reset),
        .reg1Data   (reg1Data),
        .imm        (imm),
        .memEnable  (memEnable),
        .stall      (stall),
        .branchTaken(branchTaken),
        .memHazard  (memHazard)
    );

    assign jumpNop = isJump && !jumpBubble;    // First sight of the jump
    assign stall   = regHazard || memHazard || jumpNop;
    assign nop     = stall;
    assign pcStall = stall;

    // Set only when the jump was the sole reason to stall
    always_ff @(posedge clk) begin
        if (reset) begin
            jumpBubble <= 1'b0;
        end else begin
            jumpBubble <= jumpNop && !regHazard && !memHazard;
        end
    end

endmodule

// ==== hazardUnit_checker.sv ====
`timescale 1ns/1ps

module hazardUnit_checker (
    input logic               clk,
    input logic               reset,
    input logic               nop,
    input logic               pcStall,
    input hazardPkg::fwdFlags forwards,
    input logic               jumpBubble  // Internal flag of the top level
);

    // Both outputs come from the same stall term
    stallPair: assert property (@(posedge clk) pcStall == nop)
        else $error("pcStall differs from nop");

    // Pipelines are empty right after reset, inputs are idle
    quietAfterReset: assert property (
        @(posedge clk) $fell(reset) |-> (!nop && !pcStall && (forwards == '0))
    ) else $error("Outputs active in the first cycle after reset");

    // A jump takes exactly one bubble
    singleBubble: assert property (
        @(posedge clk) disable iff (reset) jumpBubble |=> !jumpBubble
    ) else $error("Jump bubble flag high for two cycles");

endmodule

bind hazardUnit hazardUnit_checker chk0 (
    .clk       (clk),
    .reset     (reset),
    .nop       (nop),
    .pcStall   (pcStall),
    .forwards  (forwards),
    .jumpBubble(jumpBubble)
);

// ==== hazardUnit_tb.sv ====
`timescale 1ns/1ps
`include "hazard_settings.svh"

module hazardUnit_tb;

    localparam int HalfPeriod    = 4;                         // 8 ns clock
    localparam int ResetCycles   = 16;
    localparam int NumRows       = 25;
    localparam int TimeoutCycles = ResetCycles + NumRows + 20;

    localparam logic [4:0] OpAlu   = 5'b00000;
    localparam logic [4:0] OpStore = 5'b01000;
    localparam logic [4:0] OpLoad  = 5'b01001;
    localparam logic [4:0] OpJ     = `HAZ_OP_J;
    localparam logic [4:0] OpJal   = `HAZ_OP_JAL;

    // One cycle of stimulus with its expected response
    typedef struct packed {
        logic [`HAZ_DATA_W-1:0] instr;
        logic [`HAZ_REG_W-1:0]  rd;
        logic                   writeEn;
        logic                   memEnable;
        logic [`HAZ_DATA_W-1:0] reg1Data;
        logic [`HAZ_DATA_W-1:0] imm;
        logic                   branchTaken;
        logic                   expNop;
        hazardPkg::fwdFlags     expFwd;
    } stepRow;

    logic                   clk;
    logic                   reset;
    logic [`HAZ_DATA_W-1:0] instr;
    logic [`HAZ_REG_W-1:0]  rd;
    logic                   writeEn;
    logic                   memEnable;
    logic [`HAZ_DATA_W-1:0] reg1Data;
    logic [`HAZ_DATA_W-1:0] imm;
    logic                   branchTaken;
    logic                   nop;
    logic                   pcStall;
    hazardPkg::fwdFlags     forwards;

    stepRow stimTable [NumRows];
    int     rowCount   = 0;
    int     cycleCount = 0;

    hazardUnit dut0 (
        .instr      (instr),
        .rd         (rd),
        .writeEn    (writeEn),
        .memEnable  (memEnable),
        .reg1Data   (reg1Data),
        .imm        (imm),
        .branchTaken(branchTaken),
        .clk        (clk),
        .reset      (reset),
        .nop        (nop),
        .pcStall    (pcStall),
        .forwards   (forwards)
    );

    always #HalfPeriod clk = ~clk;

    // Guard against a run that never finishes
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run went past %0d clock cycles", TimeoutCycles);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Opcode, rs, rt, low five bits unused
    function automatic logic [`HAZ_DATA_W-1:0] packInstr(logic [4:0] op, int rs, int rt);
        return {op, 3'(rs), 3'(rt), 5'b00000};
    endfunction

    task automatic addRow(input logic [`HAZ_DATA_W-1:0] rowInstr, input int rowRd,
                          input int rowWe, input int rowMem,
                          input logic [`HAZ_DATA_W-1:0] rowBase,
                          input logic [`HAZ_DATA_W-1:0] rowImm, input int rowBr,
                          input int rowNop, input hazardPkg::fwdFlags rowFwd);
        stepRow r;
        r.instr       = rowInstr;
        r.rd          = 3'(rowRd);
        r.writeEn     = 1'(rowWe);
        r.memEnable   = 1'(rowMem);
        r.reg1Data    = rowBase;
        r.imm         = rowImm;
        r.branchTaken = 1'(rowBr);
        r.expNop      = 1'(rowNop);
        r.expFwd      = rowFwd;
        stimTable[rowCount] = r;
        rowCount = rowCount + 1;
    endtask

    task automatic checkEqual(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic applyRow(input stepRow r);
        instr       = r.instr;
        rd          = r.rd;
        writeEn     = r.writeEn;
        memEnable   = r.memEnable;
        reg1Data    = r.reg1Data;
        imm         = r.imm;
        branchTaken = r.branchTaken;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr       = '0;
        rd          = '0;
        writeEn     = 1'b0;
        memEnable   = 1'b0;
        reg1Data    = '0;
        imm         = '0;
        branchTaken = 1'b0;

        // Idle, then write r3 and read it back
        addRow(packInstr(OpAlu, 0, 0), 0, 0, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpAlu, 1, 1), 3, 1, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpAlu, 3, 0), 3, 1, 0, 16'h0000, 16'h0000, 0, 1, 6'b100000);
        // Same read again while r3 walks EX, MEM, WB
        // The stalled read also writes r3, so only bubbles let it clear
        addRow(packInstr(OpAlu, 3, 0), 3, 1, 0, 16'h0000, 16'h0000, 0, 1, 6'b010010);
        addRow(packInstr(OpAlu, 3, 0), 3, 1, 0, 16'h0000, 16'h0000, 0, 1, 6'b000001);
        addRow(packInstr(OpAlu, 3, 0), 3, 1, 0, 16'h0000, 16'h0000, 0, 1, 6'b000000);
        addRow(packInstr(OpAlu, 3, 0), 3, 1, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        // J bubbles once, JAL too, then r7 is busy
        addRow(packInstr(OpJ, 0, 0), 0, 0, 0, 16'h0000, 16'h0000, 0, 1, 6'b000000);
        addRow(packInstr(OpJ, 0, 0), 0, 0, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpJal, 0, 0), 0, 1, 0, 16'h0000, 16'h0000, 0, 1, 6'b000000);
        addRow(packInstr(OpJal, 0, 0), 0, 1, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpAlu, 7, 0), 0, 0, 0, 16'h0000, 16'h0000, 0, 1, 6'b100000);
        // Store to 0x0040, load from 0x0040 with carry dropped, load from 0x0042
        addRow(packInstr(OpStore, 1, 2), 0, 0, 1, 16'h0030, 16'h0010, 0, 0, 6'b000000);
        addRow(packInstr(OpLoad, 1, 0), 6, 1, 1, 16'hfff0, 16'h0050, 0, 1, 6'b000000);
        addRow(packInstr(OpLoad, 1, 0), 6, 1, 1, 16'h0040, 16'h0002, 0, 0, 6'b000000);
        // Write r5, cull it with a taken branch, read r5
        addRow(packInstr(OpAlu, 1, 1), 5, 1, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpAlu, 0, 0), 0, 0, 0, 16'h0000, 16'h0000, 1, 0, 6'b000000);
        addRow(packInstr(OpAlu, 5, 5), 0, 0, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        // Write r2, filler, rt read in EX range, rs read in MEM range
        addRow(packInstr(OpAlu, 1, 1), 2, 1, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpAlu, 3, 4), 0, 0, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpAlu, 0, 2), 0, 0, 0, 16'h0000, 16'h0000, 0, 1, 6'b000100);
        addRow(packInstr(OpAlu, 2, 0), 0, 0, 0, 16'h0000, 16'h0000, 0, 1, 6'b000001);
        // Back-to-back rt read
        addRow(packInstr(OpAlu, 1, 1), 6, 1, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);
        addRow(packInstr(OpAlu, 0, 6), 0, 0, 0, 16'h0000, 16'h0000, 0, 1, 6'b001000);
        addRow(packInstr(OpAlu, 0, 0), 0, 0, 0, 16'h0000, 16'h0000, 0, 0, 6'b000000);

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;                        // One idle cycle follows

        for (int i = 0; i < NumRows; i++) begin
            @(negedge clk);
            applyRow(stimTable[i]);
            #(HalfPeriod - 1);               // Just before the rising edge
            checkEqual("nop", 8'(nop), 8'(stimTable[i].expNop));
            checkEqual("pcStall", 8'(pcStall), 8'(stimTable[i].expNop));
            checkEqual("forwards", 8'(forwards), 8'(stimTable[i].expFwd));
        end

        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== hazardUnit.f ====
+incdir+.
hazardPkg.sv
instrDecode.sv
stagePipe.sv
regHazardCheck.sv
memHazardCheck.sv
hazardUnit.sv
hazardUnit_checker.sv
hazardUnit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hazard unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=hazardUnit_sim

verilator --binary --timing --assert \
    --top-module hazardUnit_tb \
    -f hazardUnit.f \
    -o "$EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

exit 0
